//--- Bender.yml
package:
  name: sink_streamer

sources:
  - src/sink_pkg.sv
  - src/sink_addrgen.sv
  - src/sink_addr_fifo.sv
  - src/sink_streamer.sv
  - src/sink_top.sv
  - target: test
    files:
      - verif/tb_sink_top.sv

//--- src/sink_addr_fifo.sv
// ##################################################
// sink address FIFO
// two entries between generator and streamer
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module sink_addr_fifo (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 push_valid_i,
  output logic                 push_ready_o,
  input  sink_pkg::sink_addr_t push_addr_i,
  output logic                 pop_valid_o,
  input  logic                 pop_ready_i,
  output sink_pkg::sink_addr_t pop_addr_o
);

  sink_pkg::sink_addr_t mem_q [2];
  logic                 wr_ptr_q, rd_ptr_q;
  logic [1:0]           cnt_q;  // 0..2 entries
  logic                 push, pop;

  assign push_ready_o = (cnt_q != 2'd2);
  assign pop_valid_o  = (cnt_q != 2'd0);
  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else if (clear_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      if (push && !pop) cnt_q <= cnt_q + 2'd1;
      else if (pop && !push) cnt_q <= cnt_q - 2'd1;  // both: count unchanged
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_addr_i;
  end

  assign pop_addr_o = mem_q[rd_ptr_q];  // oldest entry

endmodule

`default_nettype wire

//--- src/sink_addrgen.sv
// ##################################################
// sink address generator
// one byte address per word, base + index * stride,
// flags the last address once it is accepted
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module sink_addrgen #(
  parameter int unsigned TRANS_CNT = 16
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        enable_i,
  input  logic                        start_i,
  input  sink_pkg::sink_addrgen_cfg_t cfg_i,
  output logic                        addr_valid_o,
  input  logic                        addr_ready_i,
  output sink_pkg::sink_addr_t        addr_o,
  output logic                        last_o
);

  logic [TRANS_CNT-1:0] idx_q, idx_d;
  logic [TRANS_CNT-1:0] tot_len_q;
  sink_pkg::sink_addr_t addr_q;
  logic [15:0]          stride_q;
  logic                 busy_q;   // transfer loaded, blocks a reload
  logic                 valid_q;
  logic                 last_q;
  logic                 load;
  logic                 advance;

  assign load    = enable_i & start_i & ~busy_q;
  assign advance = enable_i & valid_q & addr_ready_i;  // address taken by the FIFO
  assign idx_d   = idx_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      idx_q   <= '0;
    end else if (clear_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      idx_q   <= '0;
    end else if (load) begin
      busy_q  <= 1'b1;
      idx_q   <= '0;
      valid_q <= (cfg_i.tot_len != '0);
      last_q  <= (cfg_i.tot_len == '0);  // empty transfer ends at once
    end else if (advance) begin
      if (idx_d == tot_len_q) begin
        valid_q <= 1'b0;
        last_q  <= 1'b1;  // held until the streamer clears us
      end else begin
        idx_q <= idx_d;
      end
    end
  end

  // running address and sampled config
  always_ff @(posedge clk_i) begin
    if (load) begin
      addr_q    <= cfg_i.base_addr;
      stride_q  <= cfg_i.stride;
      tot_len_q <= TRANS_CNT'(cfg_i.tot_len);
    end else if (advance) begin
      addr_q <= addr_q + sink_pkg::sink_addr_t'(stride_q);
    end
  end

  assign addr_valid_o = valid_q;
  assign addr_o       = addr_q;
  assign last_o       = last_q;

endmodule

`default_nettype wire

//--- src/sink_pkg.sv
// ##################################################
// sink package
// shared types of the store streamer: address,
// generator config, control and flag structs, FSM states
// ##################################################

`default_nettype none

package sink_pkg;

  // byte address on the memory port
  typedef logic [31:0] sink_addr_t;

  // one linear transfer, base + i * stride
  typedef struct packed {
    sink_addr_t  base_addr;  // first byte address
    logic [15:0] tot_len;    // words in the transfer
    logic [15:0] stride;     // bytes between words
  } sink_addrgen_cfg_t;

  // host side control
  typedef struct packed {
    logic              req_start;  // level, taken while ready_start
    sink_addrgen_cfg_t addrgen;
  } sink_ctrl_t;

  // status back to the host
  typedef struct packed {
    logic ready_start;   // idle, a new transfer may start
    logic done;          // one cycle pulse at the end
    logic addrgen_done;  // last address handed to the FIFO
  } sink_flags_t;

  // streamer FSM
  typedef enum logic [1:0] {
    SINK_IDLE    = 2'd0,
    SINK_WORKING = 2'd1,
    SINK_DONE    = 2'd2
  } sink_state_e;

endpackage

`default_nettype wire

//--- src/sink_streamer.sv
// ##################################################
// sink streamer core
// pairs stream words with addresses, shifts misaligned
// stores, counts grants and pulses done at the end
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module sink_streamer #(
  parameter int unsigned STREAM_DW  = 32,
  parameter int unsigned MEM_DW     = 64,
  parameter int unsigned MISALIGNED = 1,
  parameter int unsigned TRANS_CNT  = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   enable_i,
  input  sink_pkg::sink_ctrl_t   ctrl_i,
  output sink_pkg::sink_flags_t  flags_o,
  output logic                   addrgen_en_o,
  output logic                   addrgen_clr_o,
  input  logic                   addrgen_last_i,
  input  logic                   addr_valid_i,
  output logic                   addr_ready_o,
  input  sink_pkg::sink_addr_t   addr_i,
  input  logic                   stream_valid_i,
  output logic                   stream_ready_o,
  input  logic [STREAM_DW-1:0]   stream_data_i,
  input  logic [STREAM_DW/8-1:0] stream_strb_i,
  output logic                   mem_req_o,
  input  logic                   mem_gnt_i,
  output sink_pkg::sink_addr_t   mem_addr_o,
  output logic [MEM_DW/8-1:0]    mem_be_o,
  output logic [MEM_DW-1:0]      mem_data_o
);

  sink_pkg::sink_state_e cs, ns;
  logic                  active;  // stores allowed this cycle
  logic                  fire;    // granted store
  logic                  gen_en, gen_clr, cnt_clr;
  logic [TRANS_CNT-1:0]  cnt_q, cnt_d, tot_len;
  logic                  done_q;

  assign active = (cs != sink_pkg::SINK_IDLE) & enable_i;
  assign tot_len = TRANS_CNT'(ctrl_i.addrgen.tot_len);

  // memory port binding
  assign mem_req_o      = active & stream_valid_i & addr_valid_i;
  assign mem_addr_o     = {addr_i[31:2], 2'b00};  // word aligned
  assign stream_ready_o = active & (~stream_valid_i | (mem_gnt_i & addr_valid_i));
  assign addr_ready_o   = stream_valid_i & stream_ready_o;  // one address per word
  assign fire           = mem_req_o & mem_gnt_i;

  if (MISALIGNED == 1) begin : g_misaligned
    logic [1:0] offset;
    assign offset     = addr_i[1:0];
    // word lands at its byte offset, upper lanes stay disabled
    assign mem_data_o = MEM_DW'(stream_data_i) << {offset, 3'b000};
    assign mem_be_o   = (MEM_DW/8)'(stream_strb_i) << offset;
  end else begin : g_aligned
    assign mem_data_o = stream_data_i;
    assign mem_be_o   = stream_strb_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cs <= sink_pkg::SINK_IDLE;
    else if (clear_i) cs <= sink_pkg::SINK_IDLE;
    else if (enable_i) cs <= ns;
  end

  always_comb begin
    ns      = cs;
    gen_en  = 1'b0;
    gen_clr = 1'b0;
    cnt_clr = 1'b0;
    case (cs)
      sink_pkg::SINK_IDLE: begin
        if (ctrl_i.req_start) begin
          ns     = sink_pkg::SINK_WORKING;
          gen_en = 1'b1;  // generator samples the config now
        end
      end
      sink_pkg::SINK_WORKING: begin
        gen_en = 1'b1;
        if (addrgen_last_i) ns = sink_pkg::SINK_DONE;
      end
      sink_pkg::SINK_DONE: begin
        gen_en = 1'b1;
        if (cnt_q == tot_len) begin  // every store granted
          ns      = sink_pkg::SINK_IDLE;
          gen_en  = 1'b0;
          gen_clr = 1'b1;
          cnt_clr = 1'b1;
        end
      end
      default: ns = sink_pkg::SINK_IDLE;
    endcase
  end

  assign addrgen_en_o  = gen_en & enable_i;
  assign addrgen_clr_o = gen_clr | clear_i;

  // granted store counter
  assign cnt_d = cnt_q + 1'b1;
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cnt_q <= '0;
    else if (clear_i || (enable_i && cnt_clr)) cnt_q <= '0;
    else if (fire) cnt_q <= cnt_d;
  end

  // done in the cycle after the last grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) done_q <= 1'b0;
    else if (clear_i) done_q <= 1'b0;
    else done_q <= fire & (cnt_d == tot_len);
  end

  assign flags_o.ready_start  = (cs == sink_pkg::SINK_IDLE);
  assign flags_o.done         = done_q;
  assign flags_o.addrgen_done = addrgen_last_i;

endmodule

`default_nettype wire

//--- src/sink_top.sv
// ##################################################
// sink top level
// address generator, address FIFO and streamer core
// on one stream input and one write-only memory port
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module sink_top #(
  parameter int unsigned STREAM_DW  = 32,
  parameter int unsigned MISALIGNED = 1,
  parameter int unsigned TRANS_CNT  = 16,
  // 32 extra bits carry a shifted word
  localparam int unsigned MEM_DW    = (MISALIGNED == 1) ? STREAM_DW + 32 : STREAM_DW
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   enable_i,
  input  sink_pkg::sink_ctrl_t   ctrl_i,
  output sink_pkg::sink_flags_t  flags_o,
  input  logic                   stream_valid_i,
  output logic                   stream_ready_o,
  input  logic [STREAM_DW-1:0]   stream_data_i,
  input  logic [STREAM_DW/8-1:0] stream_strb_i,
  output logic                   mem_req_o,
  input  logic                   mem_gnt_i,
  output sink_pkg::sink_addr_t   mem_addr_o,
  output logic [MEM_DW/8-1:0]    mem_be_o,
  output logic [MEM_DW-1:0]      mem_data_o
);

  logic                 gen_valid, gen_ready;
  sink_pkg::sink_addr_t gen_addr;
  logic                 pop_valid, pop_ready;
  sink_pkg::sink_addr_t pop_addr;
  logic                 addrgen_en, addrgen_clr, addrgen_last;

  sink_addrgen #(
    .TRANS_CNT ( TRANS_CNT )
  ) i_addrgen (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( addrgen_clr     ),
    .enable_i     ( addrgen_en      ),
    .start_i      ( ctrl_i.req_start ),
    .cfg_i        ( ctrl_i.addrgen  ),
    .addr_valid_o ( gen_valid       ),
    .addr_ready_i ( gen_ready       ),
    .addr_o       ( gen_addr        ),
    .last_o       ( addrgen_last    )
  );

  sink_addr_fifo i_addr_fifo (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .clear_i      ( clear_i   ),
    .push_valid_i ( gen_valid ),
    .push_ready_o ( gen_ready ),
    .push_addr_i  ( gen_addr  ),
    .pop_valid_o  ( pop_valid ),
    .pop_ready_i  ( pop_ready ),
    .pop_addr_o   ( pop_addr  )
  );

  sink_streamer #(
    .STREAM_DW  ( STREAM_DW  ),
    .MEM_DW     ( MEM_DW     ),
    .MISALIGNED ( MISALIGNED ),
    .TRANS_CNT  ( TRANS_CNT  )
  ) i_streamer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .enable_i       ( enable_i       ),
    .ctrl_i         ( ctrl_i         ),
    .flags_o        ( flags_o        ),
    .addrgen_en_o   ( addrgen_en     ),
    .addrgen_clr_o  ( addrgen_clr    ),
    .addrgen_last_i ( addrgen_last   ),
    .addr_valid_i   ( pop_valid      ),
    .addr_ready_o   ( pop_ready      ),
    .addr_i         ( pop_addr       ),
    .stream_valid_i ( stream_valid_i ),
    .stream_ready_o ( stream_ready_o ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .mem_req_o      ( mem_req_o      ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_be_o       ( mem_be_o       ),
    .mem_data_o     ( mem_data_o     )
  );

endmodule

`default_nettype wire

//--- verif/tb_sink_top.sv
// ##################################################
// sink streamer testbench
// directed tests with a stream driver, a memory port
// model that records stores, and a watchdog
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module tb_sink_top;

  localparam int CLK_PERIOD  = 4;
  localparam int TOTAL_WORDS = 48;  // all words of all tests

  logic                  clk_i, rst_ni, clear_i, enable_i;
  sink_pkg::sink_ctrl_t  ctrl_i;
  sink_pkg::sink_flags_t flags_o;
  logic                  stream_valid_i, stream_ready_o;
  logic [31:0]           stream_data_i;
  logic [3:0]            stream_strb_i;
  logic                  mem_req_o, mem_gnt_i;
  sink_pkg::sink_addr_t  mem_addr_o;
  logic [7:0]            mem_be_o;
  logic [63:0]           mem_data_o;

  logic                 gnt_random;  // memory model mode
  logic [31:0]          word_q[$];
  logic [3:0]           strb_q[$];
  sink_pkg::sink_addr_t rec_addr[$];  // granted stores, in order
  logic [7:0]           rec_be[$];
  logic [63:0]          rec_data[$];
  time                  last_gnt_t;   // mid cycle time of the latest grant
  int                   errors, tests_run, tests_failed;

  sink_top #(
    .STREAM_DW  ( 32 ),
    .MISALIGNED ( 1  ),
    .TRANS_CNT  ( 16 )
  ) DUT (
    .clk_i, .rst_ni, .clear_i, .enable_i, .ctrl_i, .flags_o,
    .stream_valid_i, .stream_ready_o, .stream_data_i, .stream_strb_i,
    .mem_req_o, .mem_gnt_i, .mem_addr_o, .mem_be_o, .mem_data_o
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // memory model, grant always or by coin flip
  initial begin
    mem_gnt_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1 mem_gnt_i = gnt_random ? 1'($urandom % 2) : 1'b1;
    end
  end

  always @(negedge clk_i) begin  // mid cycle, inputs settled
    if (rst_ni && mem_req_o && mem_gnt_i) begin
      rec_addr.push_back(mem_addr_o);
      rec_be.push_back(mem_be_o);
      rec_data.push_back(mem_data_o);
      last_gnt_t = $time;
    end
  end

  initial begin
    #(TOTAL_WORDS * 20 * CLK_PERIOD + 2000);
    $display("watchdog: run did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic check_addr(input string name, input sink_pkg::sink_addr_t exp,
                            input sink_pkg::sink_addr_t act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_be(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [63:0] exp,
                            input logic [63:0] act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flags(input string name, input sink_pkg::sink_flags_t exp,
                             input sink_pkg::sink_flags_t act);
    if (act !== exp) begin  // ready_start, done, addrgen_done
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) $display("%s: ok", name);
    else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err0);
    end
  endtask

  task automatic fill_words(input int n);
    word_q.delete();
    strb_q.delete();
    for (int i = 0; i < n; i++) begin
      word_q.push_back($urandom);
      strb_q.push_back(4'($urandom % 16));
    end
    rec_addr.delete();
    rec_be.delete();
    rec_data.delete();
  endtask

  // level start, held for one cycle while idle
  task automatic start_transfer(input sink_pkg::sink_addr_t base, input int stride,
                                input int len);
    ctrl_i.addrgen.base_addr = base;
    ctrl_i.addrgen.stride    = 16'(stride);
    ctrl_i.addrgen.tot_len   = 16'(len);
    ctrl_i.req_start         = 1'b1;
    @(posedge clk_i);
    #1 ctrl_i.req_start = 1'b0;
  endtask

  task automatic send_words(input bit gaps);
    logic taken;
    for (int i = 0; i < word_q.size(); i++) begin
      if (gaps) begin
        stream_valid_i = 1'b0;
        repeat ($urandom % 3) begin
          @(posedge clk_i);
          #1;
        end
      end
      stream_valid_i = 1'b1;
      stream_data_i  = word_q[i];
      stream_strb_i  = strb_q[i];
      do begin
        @(negedge clk_i);
        taken = stream_ready_o;  // handshake at the coming edge
        @(posedge clk_i);
        #1;
      end while (!taken);
    end
    stream_valid_i = 1'b0;
  endtask

  // done pulse for one cycle, then idle again
  task automatic wait_done();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (flags_o.done !== 1'b1 && cycles < 1000) begin
      @(negedge clk_i);
      cycles++;
    end
    if (flags_o.done !== 1'b1) begin
      $display("done flag never rose within 1000 cycles");
      errors++;
    end else begin
      check_flags("flags_o", 3'b011, flags_o);
      if ($time - last_gnt_t != CLK_PERIOD) begin
        $display("done did not rise in the cycle right after the last grant");
        errors++;
      end
      @(negedge clk_i);
      check_flags("flags_o", 3'b100, flags_o);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_stores(input sink_pkg::sink_addr_t base, input int stride);
    sink_pkg::sink_addr_t addr_exp;
    logic [7:0]           be_exp;
    logic [63:0]          data_exp;
    if (rec_addr.size() != word_q.size()) begin
      $display("wrong store count: expected %0d stores, saw %0d",
               word_q.size(), rec_addr.size());
      errors++;
    end else begin
      for (int i = 0; i < word_q.size(); i++) begin
        addr_exp      = base + i * stride;
        addr_exp[1:0] = 2'b00;  // port is word aligned
        be_exp        = {4'b0000, strb_q[i]} << base[1:0];
        data_exp      = {32'h0, word_q[i]} << (8 * base[1:0]);
        check_addr("mem_addr_o", addr_exp, rec_addr[i]);
        check_be("mem_be_o", be_exp, rec_be[i]);
        check_data("mem_data_o", data_exp, rec_data[i]);
      end
    end
  endtask

  task automatic run_transfer(input string name, input sink_pkg::sink_addr_t base,
                              input int stride, input int n, input bit gaps,
                              input bit rnd_gnt);
    int err0;
    err0       = errors;
    gnt_random = rnd_gnt;
    fill_words(n);
    fork
      start_transfer(base, stride, n);
      send_words(gaps);
      wait_done();
    join
    check_stores(base, stride);
    report_test(name, err0);
  endtask

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    @(negedge clk_i);
    check_flags("flags_o", 3'b100, flags_o);
    check_bit("mem_req_o", 1'b0, mem_req_o);
    check_bit("stream_ready_o", 1'b0, stream_ready_o);
    @(posedge clk_i);
    #1;
    report_test("reset state", err0);
  endtask

  // clear after three stores, stream word kept constant
  task automatic test_clear();
    int err0, cycles;
    err0       = errors;
    cycles     = 0;
    gnt_random = 1'b0;
    fill_words(0);
    stream_valid_i = 1'b1;
    stream_data_i  = 32'hcafe_0001;
    stream_strb_i  = 4'hf;
    start_transfer(32'h600, 4, 10);
    while (rec_addr.size() < 3 && cycles < 200) begin
      @(posedge clk_i);  // latest granted store just completed
      #1;
      cycles++;
    end
    clear_i        = 1'b1;
    stream_valid_i = 1'b0;  // no fourth store
    @(posedge clk_i);
    #1;
    clear_i        = 1'b0;
    stream_valid_i = 1'b1;  // word offered again, idle FSM must not request
    @(negedge clk_i);
    check_flags("flags_o", 3'b100, flags_o);
    check_bit("mem_req_o", 1'b0, mem_req_o);
    if (rec_addr.size() != 3) begin
      $display("clear came after %0d stores instead of 3", rec_addr.size());
      errors++;
    end
    @(posedge clk_i);
    #1;
    stream_valid_i = 1'b0;
    report_test("clear mid transfer", err0);
  endtask

  initial begin
    void'($urandom(32'h7cb8));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    enable_i       = 1'b1;
    ctrl_i         = '0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    gnt_random     = 1'b0;
    last_gnt_t     = 0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    test_reset_state();
    run_transfer("aligned burst", 32'h100, 4, 8, 1'b0, 1'b0);
    run_transfer("misaligned burst", 32'h102, 8, 5, 1'b0, 1'b0);
    run_transfer("back-pressure", 32'h301, 12, 12, 1'b1, 1'b1);
    run_transfer("completion, first", 32'h400, 4, 4, 1'b0, 1'b0);
    run_transfer("completion, second", 32'h503, 4, 6, 1'b1, 1'b0);
    test_clear();
    run_transfer("short transfer after clear", 32'h700, 4, 3, 1'b0, 1'b0);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) $display("Simulation finished: PASS");
    else $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/sink_pkg.sv
src/sink_addrgen.sv
src/sink_addr_fifo.sv
src/sink_streamer.sv
src/sink_top.sv
verif/tb_sink_top.sv
